//--- all.f
+incdir+rtl
rtl/sad_pkg.sv
rtl/sad_window.sv
rtl/sad_cell.sv
rtl/sad_trigger.sv
rtl/sad_top.sv
test/sad_assert.sv
test/sad_tb.sv

//--- rtl/sad_cell.sv
`timescale 1ns/1ps
`include "sad_params.svh"

module sad_cell (
    input  logic             adc_sampleclk,
    input  sad_pkg::sample_t window_sample,
    input  sad_pkg::sample_t ref_sample,
    output sad_pkg::sample_t abs_diff
);

    // one bit wider, top bit tells which operand was larger
    logic [`SAD_SAMPLE_BITS:0] diff;

    assign diff = {1'b0, window_sample} - {1'b0, ref_sample};

    // no reset, the result is ignored until the window is valid
    always_ff @(posedge adc_sampleclk) begin
        if (diff[`SAD_SAMPLE_BITS])
            abs_diff <= ref_sample - window_sample; // window below reference
        else
            abs_diff <= diff[`SAD_SAMPLE_BITS-1:0];
    end

endmodule

//--- rtl/sad_params.svh
`ifndef SAD_PARAMS_SVH
`define SAD_PARAMS_SVH

// number of reference samples, one cell each
`define SAD_REF_SAMPLES 8

`define SAD_SAMPLE_BITS 8 // adc sample width

// holds eight times 255 without overflow
`define SAD_SUM_BITS 11

`define SAD_COUNT_BITS 8
`define SAD_IDX_BITS 3 // reference index

`endif

//--- rtl/sad_pkg.sv
`include "sad_params.svh"

package sad_pkg;

    typedef logic [`SAD_SAMPLE_BITS-1:0] sample_t; // adc or reference sample
    typedef logic [`SAD_SUM_BITS-1:0] sum_t; // sad value or threshold
    typedef logic [`SAD_COUNT_BITS-1:0] count_t; // triggers since arming

    // configuration opcodes
    typedef enum logic [1:0] {
        op_ref       = 2'd0, // reference sample at cfg_index
        op_threshold = 2'd1,
        op_mode      = 2'd2, // data bit 0 selects multiple triggers
        op_nop       = 2'd3
    } cfg_op_e;

    // trigger controller
    typedef enum logic [1:0] {
        st_idle  = 2'd0, // not armed
        st_armed = 2'd1, // may fire
        st_fired = 2'd2  // single mode, waiting for a new arm
    } trig_state_e;

endpackage

//--- rtl/sad_top.sv
`timescale 1ns/1ps
`include "sad_params.svh"

module sad_top (
    input  logic             adc_sampleclk,
    input  logic             reset,
    input  sad_pkg::sample_t adc_data,
    input  logic             adc_valid,
    input  logic             arm,
    input  logic             cfg_write,
    input  sad_pkg::cfg_op_e cfg_op,
    input  logic [`SAD_IDX_BITS-1:0] cfg_index,
    input  sad_pkg::sum_t    cfg_data,
    output logic             trigger,
    output logic             triggered,
    output sad_pkg::count_t  num_triggers
);

    sad_pkg::sample_t window_sample [0:`SAD_REF_SAMPLES-1];
    sad_pkg::sample_t ref_sample [0:`SAD_REF_SAMPLES-1];
    sad_pkg::sample_t abs_diff [0:`SAD_REF_SAMPLES-1];
    logic             window_valid;

    sad_window u_window (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .adc_data      (adc_data),
        .adc_valid     (adc_valid),
        .arm           (arm),
        .cfg_write     (cfg_write),
        .cfg_op        (cfg_op),
        .cfg_index     (cfg_index),
        .cfg_data      (cfg_data),
        .window_sample (window_sample),
        .ref_sample    (ref_sample),
        .window_valid  (window_valid)
    );

    // one cell per window position
    for (genvar k = 0; k < `SAD_REF_SAMPLES; k++) begin : gen_cells
        sad_cell u_cell (
            .adc_sampleclk (adc_sampleclk),
            .window_sample (window_sample[k]),
            .ref_sample    (ref_sample[k]),
            .abs_diff      (abs_diff[k])
        );
    end

    sad_trigger u_trigger (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .abs_diff      (abs_diff),
        .window_valid  (window_valid),
        .arm           (arm),
        .cfg_write     (cfg_write),
        .cfg_op        (cfg_op),
        .cfg_data      (cfg_data),
        .trigger       (trigger),
        .triggered     (triggered),
        .num_triggers  (num_triggers)
    );

endmodule

//--- rtl/sad_trigger.sv
`timescale 1ns/1ps
`include "sad_params.svh"

module sad_trigger (
    input  logic             adc_sampleclk,
    input  logic             reset,
    input  sad_pkg::sample_t abs_diff [0:`SAD_REF_SAMPLES-1],
    input  logic             window_valid,
    input  logic             arm,
    input  logic             cfg_write,
    input  sad_pkg::cfg_op_e cfg_op,
    input  sad_pkg::sum_t    cfg_data,
    output logic             trigger,
    output logic             triggered,
    output sad_pkg::count_t  num_triggers
);

    sad_pkg::trig_state_e state;
    sad_pkg::trig_state_e state_next;
    sad_pkg::sum_t        threshold;
    sad_pkg::sum_t        sum;
    logic                 multiple; // 0 = single trigger mode
    logic                 valid_d; // window_valid lined up with the cells
    logic                 fire;

    // adder tree, left to synthesis
    always_comb begin
        sum = '0;
        for (int k = 0; k < `SAD_REF_SAMPLES; k++)
            sum = sum + sad_pkg::sum_t'(abs_diff[k]);
    end

    // arm wins over a window still in flight
    assign fire = valid_d && (sum <= threshold) && (state == sad_pkg::st_armed) && !arm;

    always_comb begin
        state_next = state;
        case (state)
            sad_pkg::st_idle:  if (arm) state_next = sad_pkg::st_armed;
            sad_pkg::st_armed: begin
                if (fire && !multiple)
                    state_next = sad_pkg::st_fired; // single shot used up
            end
            sad_pkg::st_fired: if (arm) state_next = sad_pkg::st_armed;
            default:           state_next = sad_pkg::st_idle;
        endcase
    end

    // configuration
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            threshold <= '0;
            multiple  <= 1'b0;
        end else if (cfg_write) begin
            case (cfg_op)
                sad_pkg::op_threshold: threshold <= cfg_data;
                sad_pkg::op_mode:      multiple  <= cfg_data[0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state        <= sad_pkg::st_idle;
            valid_d      <= 1'b0;
            trigger      <= 1'b0;
            triggered    <= 1'b0;
            num_triggers <= '0;
        end else begin
            state   <= state_next;
            valid_d <= window_valid && !arm; // drop windows from before the arm
            trigger <= fire;
            if (arm) begin
                triggered    <= 1'b0;
                num_triggers <= '0;
            end else if (fire) begin
                triggered    <= 1'b1;
                num_triggers <= num_triggers + 1'b1;
            end
        end
    end

endmodule

//--- rtl/sad_window.sv
`timescale 1ns/1ps
`include "sad_params.svh"

module sad_window (
    input  logic               adc_sampleclk,
    input  logic               reset,
    input  sad_pkg::sample_t   adc_data,
    input  logic               adc_valid,
    input  logic               arm,
    input  logic               cfg_write,
    input  sad_pkg::cfg_op_e   cfg_op,
    input  logic [`SAD_IDX_BITS-1:0] cfg_index,
    input  sad_pkg::sum_t      cfg_data,
    output sad_pkg::sample_t   window_sample [0:`SAD_REF_SAMPLES-1],
    output sad_pkg::sample_t   ref_sample [0:`SAD_REF_SAMPLES-1],
    output logic               window_valid
);

    // one extra bit so the counter can reach a full window
    logic [`SAD_IDX_BITS:0] fill;
    logic [`SAD_IDX_BITS:0] fill_next;

    // sliding window, position 0 is the oldest sample
    always_ff @(posedge adc_sampleclk) begin
        if (adc_valid) begin
            for (int k = 0; k < `SAD_REF_SAMPLES - 1; k++)
                window_sample[k] <= window_sample[k+1];
            window_sample[`SAD_REF_SAMPLES-1] <= adc_data; // newest
        end
    end

    // reference storage, written one sample at a time
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            for (int k = 0; k < `SAD_REF_SAMPLES; k++)
                ref_sample[k] <= '0;
        end else if (cfg_write && cfg_op == sad_pkg::op_ref) begin
            ref_sample[cfg_index] <= cfg_data[`SAD_SAMPLE_BITS-1:0];
        end
    end

    // a sample taken together with arm is the first of the new fill
    always_comb begin
        if (arm)
            fill_next = {{`SAD_IDX_BITS{1'b0}}, adc_valid};
        else if (adc_valid && fill != `SAD_REF_SAMPLES)
            fill_next = fill + 1'b1;
        else
            fill_next = fill; // saturates at a full window
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            fill         <= '0;
            window_valid <= 1'b0;
        end else begin
            fill         <= fill_next;
            window_valid <= adc_valid && (fill_next == `SAD_REF_SAMPLES);
        end
    end

endmodule

//--- test/sad_assert.sv
`timescale 1ns/1ps

module sad_assert (
    input logic                 adc_sampleclk,
    input logic                 reset,
    input logic                 trigger,
    input logic                 arm,
    input sad_pkg::trig_state_e state,
    input logic                 multiple,
    input sad_pkg::count_t      num_triggers
);

    int errors = 0;

    // a trigger fired in single mode is a lone pulse
    pulse_width: assert property (@(posedge adc_sampleclk) disable iff (reset)
        (trigger && !$past(multiple)) |=> !trigger)
        else begin
            $error("trigger high on two consecutive cycles in single mode");
            errors++;
        end

    // single shot used up, nothing more until the next arm
    single_shot: assert property (@(posedge adc_sampleclk) disable iff (reset)
        (state == sad_pkg::st_fired && !multiple) |=> !trigger)
        else begin
            $error("trigger after firing in single mode");
            errors++;
        end

    count_source: assert property (@(posedge adc_sampleclk) disable iff (reset)
        $changed(num_triggers) |-> (trigger || $past(arm)))
        else begin
            $error("num_triggers changed without a trigger or an arm");
            errors++;
        end

endmodule

bind sad_trigger sad_assert u_assert (
    .adc_sampleclk (adc_sampleclk),
    .reset         (reset),
    .trigger       (trigger),
    .arm           (arm),
    .state         (state),
    .multiple      (multiple),
    .num_triggers  (num_triggers)
);

//--- test/sad_tb.sv
`timescale 1ns/1ps
`include "sad_params.svh"

module sad_tb;

    logic                     adc_sampleclk = 1'b0;
    logic                     reset;
    sad_pkg::sample_t         adc_data;
    logic                     adc_valid;
    logic                     arm;
    logic                     cfg_write;
    sad_pkg::cfg_op_e         cfg_op;
    logic [`SAD_IDX_BITS-1:0] cfg_index;
    sad_pkg::sum_t            cfg_data;
    logic                     trigger;
    logic                     triggered;
    sad_pkg::count_t          num_triggers;

    int fd;
    int cycles = 0; // rising edges since time 0
    int cycle_limit = 0;
    int cyc = 0; // falling edges since the trace started

    // expectations in flight, one entry per sample line
    int due_q[$];
    int trig_q[$];
    int count_q[$];

    sad_top dut (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .adc_data      (adc_data),
        .adc_valid     (adc_valid),
        .arm           (arm),
        .cfg_write     (cfg_write),
        .cfg_op        (cfg_op),
        .cfg_index     (cfg_index),
        .cfg_data      (cfg_data),
        .trigger       (trigger),
        .triggered     (triggered),
        .num_triggers  (num_triggers)
    );

    always #10 adc_sampleclk = ~adc_sampleclk; // 20 ns period

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    always @(posedge adc_sampleclk) begin
        cycles++;
        if (cycle_limit != 0 && cycles > cycle_limit)
            report_failure("the run did not finish within the cycle limit");
    end

    task automatic check_due();
        int exp_trig;
        int exp_count;
        while (due_q.size() != 0 && due_q[0] == cyc) begin
            void'(due_q.pop_front());
            exp_trig  = trig_q.pop_front();
            exp_count = count_q.pop_front();
            assert (trigger === exp_trig[0])
                else report_failure($sformatf("[FAIL] %0t trigger is %b, expected %0d",
                    $time, trigger, exp_trig));
            assert (num_triggers === sad_pkg::count_t'(exp_count))
                else report_failure($sformatf("[FAIL] %0t num_triggers is %0d, expected %0d",
                    $time, num_triggers, exp_count));
            // level stays up from the first trigger until the next arm
            assert (triggered === (exp_count != 0))
                else report_failure($sformatf("[FAIL] %0t triggered is %b, expected %0b",
                    $time, triggered, exp_count != 0));
        end
    endtask

    task automatic next_cycle();
        @(negedge adc_sampleclk);
        cyc++;
        check_due();
        assert (dut.u_trigger.u_assert.errors == 0)
            else report_failure("a bound assertion on the trigger block failed");
    endtask

    task automatic drive_line(input byte op);
        int a;
        int b;
        int c;
        int got;
        adc_valid = 1'b0;
        arm       = 1'b0;
        cfg_write = 1'b0;
        case (op)
            "C": begin
                got = $fscanf(fd, "%d %d %d", a, b, c);
                if (got != 3) begin
                    report_failure("malformed configuration line in the trace");
                end else begin
                    cfg_write = 1'b1;
                    cfg_op    = sad_pkg::cfg_op_e'(a[1:0]);
                    cfg_index = b[`SAD_IDX_BITS-1:0];
                    cfg_data  = c[`SAD_SUM_BITS-1:0];
                end
            end
            "A": arm = 1'b1;
            "I": ;
            "S": begin
                got = $fscanf(fd, "%d %d %d", a, b, c);
                if (got != 3) begin
                    report_failure("malformed sample line in the trace");
                end else begin
                    adc_valid = 1'b1;
                    adc_data  = a[`SAD_SAMPLE_BITS-1:0];
                    due_q.push_back(cyc + 3); // two rising edges after the sample edge
                    trig_q.push_back(b);
                    count_q.push_back(c);
                end
            end
            default: report_failure($sformatf("unknown op letter %c in the trace", op));
        endcase
    endtask

    initial begin
        string line;
        int    n_lines;
        byte   op;
        reset     = 1'b1;
        adc_data  = '0;
        adc_valid = 1'b0;
        arm       = 1'b0;
        cfg_write = 1'b0;
        cfg_op    = sad_pkg::op_nop;
        cfg_index = '0;
        cfg_data  = '0;

        // run length follows from the trace length
        n_lines = 0;
        fd = $fopen("test/sad_trace.txt", "r");
        if (fd == 0)
            report_failure("could not open test/sad_trace.txt");
        while ($fgets(line, fd) != 0)
            n_lines++;
        $fclose(fd);
        cycle_limit = n_lines + 20;
        fd = $fopen("test/sad_trace.txt", "r");

        repeat (4) @(posedge adc_sampleclk);
        @(negedge adc_sampleclk);
        reset = 1'b0;

        while ($fscanf(fd, " %c", op) == 1) begin
            if (op == "#") begin
                void'($fgets(line, fd)); // rest of a comment line
            end else begin
                drive_line(op);
                next_cycle();
            end
        end
        $fclose(fd);

        // let the last samples reach the trigger output
        adc_valid = 1'b0;
        arm       = 1'b0;
        cfg_write = 1'b0;
        repeat (3) next_cycle();

        if (due_q.size() != 0) begin
            report_failure("the trace ended with expected results still unchecked");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

//--- test/sad_trace.txt
# one line per clock cycle, op letter first
# C op index data | A | I | S sample expected_trigger expected_count
# samples before any arm, references and threshold still 0
S 0 0 0
S 0 0 0
S 0 0 0
S 0 0 0
S 0 0 0
S 0 0 0
S 0 0 0
S 0 0 0
I
# reference ramp 10 to 80, threshold 0
C 0 0 10
C 0 1 20
C 0 2 30
C 0 3 40
C 0 4 50
C 0 5 60
C 0 6 70
C 0 7 80
C 1 0 0
# single mode, exact match on the eighth sample
A
S 10 0 0
S 20 0 0
S 30 0 0
S 40 0 0
S 50 0 0
S 60 0 0
S 70 0 0
S 80 1 1
I
# every window matches now but the single shot is used up
C 1 0 2040
S 10 0 1
S 20 0 1
# multiple mode, fill restarts at the arm
C 2 0 1
I
A
S 200 0 0
S 150 0 0
S 100 0 0
S 50 0 0
S 0 0 0
S 255 0 0
S 128 0 0
S 64 1 1
S 32 1 2
S 16 1 3
I
# threshold 40, window sums 40 then 41
C 1 0 40
A
S 5 0 0
S 15 0 0
S 25 0 0
S 35 0 0
S 45 0 0
S 55 0 0
S 65 0 0
S 75 1 1
S 74 0 1
I
